// ==== include/gcu_defines.svh ====
`ifndef GCU_DEFINES_SVH
`define GCU_DEFINES_SVH

// data path and address widths
`define GCU_WORD_W          16
`define GCU_VRAM_AW         13
`define GCU_LAYER_AW        11
`define GCU_BEAM_W          9
`define GCU_REG_SEL_W       8

// select keeps bit 7 and the low nibble
`define GCU_REG_SEL_MASK    8'h8F

// scroll register codes, bit 7 ignored on write
`define GCU_REG_BG_X        8'h00
`define GCU_REG_BG_Y        8'h01
`define GCU_REG_FG_X        8'h02
`define GCU_REG_FG_Y        8'h03
`define GCU_REG_TXT_X       8'h04
`define GCU_REG_TXT_Y       8'h05
`define GCU_REG_SPR_X       8'h06
`define GCU_REG_SPR_Y       8'h07

// selecting any of these holds VINT low
`define GCU_REG_VINT_A      8'h0E
`define GCU_REG_VINT_B      8'h0F
`define GCU_REG_VINT_C      8'h8F

// video RAM layer regions, word addresses
`define GCU_SCR0_BASE       13'h0000
`define GCU_SCR1_BASE       13'h0800
`define GCU_SCR2_BASE       13'h1000
`define GCU_SPR_BASE        13'h1800
`define GCU_SPR_END         13'h1C00

`define GCU_VINT_LINE       9'd230

`endif

// ==== src/gcu_pkg.sv ====
`include "gcu_defines.svh"

package gcu_pkg;

    // cpu data and ram word
    typedef logic [`GCU_WORD_W-1:0] word_t;

    // main video RAM word address
    typedef logic [`GCU_VRAM_AW-1:0] vram_addr_t;

    // address inside one layer mirror
    typedef logic [`GCU_LAYER_AW-1:0] layer_addr_t;

    // beam position or sync limit
    typedef logic [`GCU_BEAM_W-1:0] beam_t;

    // scroll register select code
    typedef logic [`GCU_REG_SEL_W-1:0] reg_sel_t;

    // two-phase read sequence
    typedef enum logic [1:0] {
        RD_ADDR,
        RD_WAIT,
        RD_LATCH,
        RD_DONE
    } read_state_t;

endpackage

// ==== src/gcu_dual_ram.sv ====
`timescale 1ns/100ps

module gcu_dual_ram #(
    parameter int DATA_W = 16,
    parameter int ADDR_W = 11
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,
    input  logic [ADDR_W-1:0] raddr,
    output logic [DATA_W-1:0] rdata
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [DATA_W-1:0] mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== src/gcu_cmd_ctrl.sv ====
`timescale 1ns/100ps
`include "gcu_defines.svh"

module gcu_cmd_ctrl (
    input  logic                CLK96,
    input  logic                RESET96,
    input  gcu_pkg::word_t      din,
    input  logic                op_set_ram_ptr,
    input  logic                op_write_ram,
    input  logic                op_read_ram_h,
    input  logic                op_read_ram_l,
    input  logic                op_select_reg,
    input  logic                op_write_reg,
    input  gcu_pkg::word_t      vram_rdata,
    output logic                ack,
    output gcu_pkg::word_t      dout,
    output logic                vram_we,
    output gcu_pkg::vram_addr_t vram_addr,
    output gcu_pkg::word_t      vram_wdata
);

    import gcu_pkg::*;

    logic [5:0]  op_vec;
    logic [5:0]  last_op;
    logic        op_changed;
    vram_addr_t  ptr;
    logic        wr_phase;
    logic        wr_phase_cur;
    read_state_t rd_state;
    read_state_t rd_state_cur;

    assign op_vec = {op_select_reg, op_write_reg, op_set_ram_ptr,
                     op_write_ram, op_read_ram_h, op_read_ram_l};

    // a new op starts its sequence from the beginning
    assign op_changed   = (op_vec != last_op);
    assign wr_phase_cur = op_changed ? 1'b0 : wr_phase;
    assign rd_state_cur = op_changed ? RD_ADDR : rd_state;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            ack      <= 1'b1;
            vram_we  <= 1'b0;
            ptr      <= '0;
            wr_phase <= 1'b0;
            rd_state <= RD_ADDR;
            last_op  <= '0;
        end else begin
            last_op <= op_vec;
            if (op_changed) begin
                wr_phase <= 1'b0;
                rd_state <= RD_ADDR;
            end

            if (op_select_reg || op_write_reg) begin
                // handled in the scroll register block
                ack     <= 1'b1;
                vram_we <= 1'b0;
            end else if (op_set_ram_ptr) begin
                ptr     <= din[`GCU_VRAM_AW-1:0];
                ack     <= 1'b1;
                vram_we <= 1'b0;
            end else if (op_write_ram) begin
                if (!wr_phase_cur) begin
                    vram_addr <= ptr;
                    vram_wdata <= din;
                    vram_we   <= 1'b1;
                    wr_phase  <= 1'b1;
                    ack       <= 1'b0;
                end else if (vram_we) begin
                    // second edge, write done
                    vram_we <= 1'b0;
                    ptr     <= ptr + 1'b1;
                    ack     <= 1'b1;
                end else begin
                    ack <= 1'b1;
                end
            end else if (op_read_ram_h || op_read_ram_l) begin
                case (rd_state_cur)
                    RD_ADDR: begin
                        // low half sits one word above the pointer
                        vram_addr <= ptr + vram_addr_t'(op_read_ram_l);
                        vram_we   <= 1'b0;
                        ack       <= 1'b0;
                        rd_state  <= RD_WAIT;
                    end
                    RD_WAIT: begin
                        rd_state <= RD_LATCH;
                    end
                    RD_LATCH: begin
                        dout     <= vram_rdata;
                        ack      <= 1'b1;
                        rd_state <= RD_DONE;
                    end
                    default: begin
                        ack <= 1'b1;
                    end
                endcase
            end else begin
                ack      <= 1'b1;
                vram_we  <= 1'b0;
                wr_phase <= 1'b0;
                rd_state <= RD_ADDR;
            end
        end
    end

    // cpu side drives one op level at a time
    a_one_op: assert property (@(posedge CLK96) disable iff (RESET96)
        $onehot0(op_vec))
        else $error("two op levels high at once");

    // each held write produces a single strobe
    a_we_pulse: assert property (@(posedge CLK96) disable iff (RESET96)
        vram_we |=> !vram_we)
        else $error("vram_we high for two cycles");

endmodule

// ==== src/gcu_scroll_regs.sv ====
`timescale 1ns/100ps
`include "gcu_defines.svh"

module gcu_scroll_regs (
    input  logic           CLK96,
    input  logic           RESET96,
    input  gcu_pkg::word_t din,
    input  logic           op_select_reg,
    input  logic           op_write_reg,
    output gcu_pkg::word_t bg_scroll_x,
    output gcu_pkg::word_t bg_scroll_y,
    output gcu_pkg::word_t fg_scroll_x,
    output gcu_pkg::word_t fg_scroll_y,
    output gcu_pkg::word_t txt_scroll_x,
    output gcu_pkg::word_t txt_scroll_y,
    output gcu_pkg::word_t spr_scroll_x,
    output gcu_pkg::word_t spr_scroll_y,
    output logic           vint_hold
);

    import gcu_pkg::*;

    reg_sel_t sel;
    reg_sel_t wr_code;

    // bit 7 only selects the flip variant, same register
    assign wr_code = {1'b0, sel[`GCU_REG_SEL_W-2:0]};

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sel          <= '1;
            bg_scroll_x  <= '0;
            bg_scroll_y  <= '0;
            fg_scroll_x  <= '0;
            fg_scroll_y  <= '0;
            txt_scroll_x <= '0;
            txt_scroll_y <= '0;
            spr_scroll_x <= '0;
            spr_scroll_y <= '0;
        end else if (op_select_reg) begin
            sel <= din[`GCU_REG_SEL_W-1:0] & `GCU_REG_SEL_MASK;
        end else if (op_write_reg) begin
            case (wr_code)
                `GCU_REG_BG_X:  bg_scroll_x  <= din;
                `GCU_REG_BG_Y:  bg_scroll_y  <= din;
                `GCU_REG_FG_X:  fg_scroll_x  <= din;
                `GCU_REG_FG_Y:  fg_scroll_y  <= din;
                `GCU_REG_TXT_X: txt_scroll_x <= din;
                `GCU_REG_TXT_Y: txt_scroll_y <= din;
                `GCU_REG_SPR_X: spr_scroll_x <= din;
                `GCU_REG_SPR_Y: spr_scroll_y <= din;
                default: begin
                    // other codes have no register here
                end
            endcase
        end
    end

    // interrupt ack codes keep VINT asserted
    assign vint_hold = (sel == `GCU_REG_VINT_A) ||
                       (sel == `GCU_REG_VINT_B) ||
                       (sel == `GCU_REG_VINT_C);

endmodule

// ==== src/gcu_layer_rams.sv ====
`timescale 1ns/100ps
`include "gcu_defines.svh"

module gcu_layer_rams (
    input  logic                 CLK96,
    input  logic                 vram_we,
    input  gcu_pkg::vram_addr_t  vram_addr,
    input  gcu_pkg::word_t       vram_wdata,
    input  gcu_pkg::layer_addr_t scr0_addr,
    input  gcu_pkg::layer_addr_t scr1_addr,
    input  gcu_pkg::layer_addr_t scr2_addr,
    input  gcu_pkg::layer_addr_t spr_addr,
    output gcu_pkg::word_t       scr0_data,
    output gcu_pkg::word_t       scr1_data,
    output gcu_pkg::word_t       scr2_data,
    output gcu_pkg::word_t       spr_data
);

    import gcu_pkg::*;

    layer_addr_t waddr;
    logic        scr0_we;
    logic        scr1_we;
    logic        scr2_we;
    logic        spr_we;

    assign waddr = vram_addr[`GCU_LAYER_AW-1:0];

    // region decode, anything from 0x1C00 up has no mirror
    assign scr0_we = vram_we && (vram_addr < `GCU_SCR1_BASE);
    assign scr1_we = vram_we && (vram_addr >= `GCU_SCR1_BASE) && (vram_addr < `GCU_SCR2_BASE);
    assign scr2_we = vram_we && (vram_addr >= `GCU_SCR2_BASE) && (vram_addr < `GCU_SPR_BASE);
    assign spr_we  = vram_we && (vram_addr >= `GCU_SPR_BASE) && (vram_addr < `GCU_SPR_END);

    gcu_dual_ram #(.DATA_W(`GCU_WORD_W), .ADDR_W(`GCU_LAYER_AW)) scr0_ram_inst (
        .clk(CLK96), .we(scr0_we), .waddr(waddr), .wdata(vram_wdata),
        .raddr(scr0_addr), .rdata(scr0_data)
    );

    gcu_dual_ram #(.DATA_W(`GCU_WORD_W), .ADDR_W(`GCU_LAYER_AW)) scr1_ram_inst (
        .clk(CLK96), .we(scr1_we), .waddr(waddr), .wdata(vram_wdata),
        .raddr(scr1_addr), .rdata(scr1_data)
    );

    gcu_dual_ram #(.DATA_W(`GCU_WORD_W), .ADDR_W(`GCU_LAYER_AW)) scr2_ram_inst (
        .clk(CLK96), .we(scr2_we), .waddr(waddr), .wdata(vram_wdata),
        .raddr(scr2_addr), .rdata(scr2_data)
    );

    gcu_dual_ram #(.DATA_W(`GCU_WORD_W), .ADDR_W(`GCU_LAYER_AW)) spr_ram_inst (
        .clk(CLK96), .we(spr_we), .waddr(waddr), .wdata(vram_wdata),
        .raddr(spr_addr), .rdata(spr_data)
    );

    // regions must not overlap
    a_one_mirror: assert property (@(posedge CLK96)
        $onehot0({scr0_we, scr1_we, scr2_we, spr_we}))
        else $error("more than one layer mirror written");

endmodule

// ==== src/gcu_video_timing.sv ====
`timescale 1ns/100ps
`include "gcu_defines.svh"

module gcu_video_timing (
    input  logic           CLK96,
    input  logic           RESET96,
    input  gcu_pkg::beam_t v,
    input  gcu_pkg::beam_t h,
    input  gcu_pkg::beam_t hs_start,
    input  gcu_pkg::beam_t hs_end,
    input  gcu_pkg::beam_t vs_start,
    input  gcu_pkg::beam_t vs_end,
    input  logic           vint_hold,
    output logic           hsync,
    output logic           vsync,
    output logic           fblank,
    output logic           vint
);

    import gcu_pkg::*;

    logic hs_active;
    logic vs_active;
    logic vint_active;

    // horizontal window is exclusive, vertical inclusive
    assign hs_active   = (h > hs_start) && (h < hs_end);
    assign vs_active   = (v >= vs_start) && (v <= vs_end);
    assign vint_active = (v == beam_t'(`GCU_VINT_LINE)) || vint_hold;

    // all outputs active low
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            fblank <= 1'b1;
            vint   <= 1'b1;
        end else begin
            hsync  <= !hs_active;
            vsync  <= !vs_active;
            fblank <= !(hs_active || vs_active);
            vint   <= !vint_active;
        end
    end

endmodule

// ==== src/gcu_top.sv ====
`timescale 1ns/100ps
`include "gcu_defines.svh"

module gcu_top (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  gcu_pkg::word_t       din,
    output gcu_pkg::word_t       dout,
    output logic                 ack,
    input  logic                 op_select_reg,
    input  logic                 op_write_reg,
    input  logic                 op_set_ram_ptr,
    input  logic                 op_write_ram,
    input  logic                 op_read_ram_h,
    input  logic                 op_read_ram_l,
    output gcu_pkg::word_t       bg_scroll_x,
    output gcu_pkg::word_t       bg_scroll_y,
    output gcu_pkg::word_t       fg_scroll_x,
    output gcu_pkg::word_t       fg_scroll_y,
    output gcu_pkg::word_t       txt_scroll_x,
    output gcu_pkg::word_t       txt_scroll_y,
    output gcu_pkg::word_t       spr_scroll_x,
    output gcu_pkg::word_t       spr_scroll_y,
    input  gcu_pkg::layer_addr_t scr0_addr,
    input  gcu_pkg::layer_addr_t scr1_addr,
    input  gcu_pkg::layer_addr_t scr2_addr,
    input  gcu_pkg::layer_addr_t spr_addr,
    output gcu_pkg::word_t       scr0_data,
    output gcu_pkg::word_t       scr1_data,
    output gcu_pkg::word_t       scr2_data,
    output gcu_pkg::word_t       spr_data,
    input  gcu_pkg::beam_t       v,
    input  gcu_pkg::beam_t       h,
    input  gcu_pkg::beam_t       hs_start,
    input  gcu_pkg::beam_t       hs_end,
    input  gcu_pkg::beam_t       vs_start,
    input  gcu_pkg::beam_t       vs_end,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 fblank,
    output logic                 vint
);

    import gcu_pkg::*;

    logic       vram_we;
    vram_addr_t vram_addr;
    word_t      vram_wdata;
    word_t      vram_rdata;
    logic       vint_hold;

    gcu_cmd_ctrl gcu_cmd_ctrl_inst (
        .CLK96(CLK96), .RESET96(RESET96), .din(din),
        .op_set_ram_ptr(op_set_ram_ptr), .op_write_ram(op_write_ram),
        .op_read_ram_h(op_read_ram_h), .op_read_ram_l(op_read_ram_l),
        .op_select_reg(op_select_reg), .op_write_reg(op_write_reg),
        .vram_rdata(vram_rdata), .ack(ack), .dout(dout), .vram_we(vram_we),
        .vram_addr(vram_addr), .vram_wdata(vram_wdata)
    );

    gcu_scroll_regs gcu_scroll_regs_inst (
        .CLK96(CLK96), .RESET96(RESET96), .din(din),
        .op_select_reg(op_select_reg), .op_write_reg(op_write_reg),
        .bg_scroll_x(bg_scroll_x), .bg_scroll_y(bg_scroll_y),
        .fg_scroll_x(fg_scroll_x), .fg_scroll_y(fg_scroll_y),
        .txt_scroll_x(txt_scroll_x), .txt_scroll_y(txt_scroll_y),
        .spr_scroll_x(spr_scroll_x), .spr_scroll_y(spr_scroll_y),
        .vint_hold(vint_hold)
    );

    // main video RAM, read back through the cpu port
    gcu_dual_ram #(.DATA_W(`GCU_WORD_W), .ADDR_W(`GCU_VRAM_AW)) vram_inst (
        .clk(CLK96), .we(vram_we), .waddr(vram_addr), .wdata(vram_wdata),
        .raddr(vram_addr), .rdata(vram_rdata)
    );

    gcu_layer_rams gcu_layer_rams_inst (
        .CLK96(CLK96), .vram_we(vram_we), .vram_addr(vram_addr),
        .vram_wdata(vram_wdata),
        .scr0_addr(scr0_addr), .scr1_addr(scr1_addr),
        .scr2_addr(scr2_addr), .spr_addr(spr_addr),
        .scr0_data(scr0_data), .scr1_data(scr1_data),
        .scr2_data(scr2_data), .spr_data(spr_data)
    );

    gcu_video_timing gcu_video_timing_inst (
        .CLK96(CLK96), .RESET96(RESET96), .v(v), .h(h),
        .hs_start(hs_start), .hs_end(hs_end),
        .vs_start(vs_start), .vs_end(vs_end), .vint_hold(vint_hold),
        .hsync(hsync), .vsync(vsync), .fblank(fblank), .vint(vint)
    );

endmodule

// ==== tests/tb_gcu.sv ====
`timescale 1ns/100ps
`include "gcu_defines.svh"

module tb_gcu;

    import gcu_pkg::*;

    localparam int OP_IDLE    = 0;
    localparam int OP_SEL     = 1;
    localparam int OP_WR_REG  = 2;
    localparam int OP_SET_PTR = 3;
    localparam int OP_WR_RAM  = 4;
    localparam int OP_RD_H    = 5;
    localparam int OP_RD_L    = 6;

    logic        CLK96 = 1'b0;
    logic        RESET96;
    word_t       din;
    word_t       dout;
    logic        ack;
    logic        op_select_reg, op_write_reg, op_set_ram_ptr;
    logic        op_write_ram, op_read_ram_h, op_read_ram_l;
    word_t       bg_scroll_x, bg_scroll_y, fg_scroll_x, fg_scroll_y;
    word_t       txt_scroll_x, txt_scroll_y, spr_scroll_x, spr_scroll_y;
    layer_addr_t scr0_addr, scr1_addr, scr2_addr, spr_addr;
    word_t       scr0_data, scr1_data, scr2_data, spr_data;
    beam_t       v, h, hs_start, hs_end, vs_start, vs_end;
    logic        hsync, vsync, fblank, vint;

    integer seed = 32'hbfc7_4fd5;
    int     errors = 0;
    int     timeouts = 0;
    word_t  exp_scroll [8];

    always #4 CLK96 = ~CLK96;

    gcu_top gcu_top_inst (.*);

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word_differs(input string what, input word_t got, input word_t bad);
        if (got === bad) begin
            errors++;
            $display("ERR %0t: %s is %h, must differ from %h", $time, what, got, bad);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ack is sampled on the falling edge
    task automatic check_ack_wait(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge CLK96);
        while (ack !== level && cycles < 50) begin
            @(negedge CLK96);
            cycles++;
        end
        if (ack !== level) begin
            timeouts++;
            $display("timeout at %0t: ACK did not reach %b within 50 cycles during %s",
                     $time, level, what);
        end
    endtask

    task automatic set_ops(input int op);
        op_select_reg  <= (op == OP_SEL);
        op_write_reg   <= (op == OP_WR_REG);
        op_set_ram_ptr <= (op == OP_SET_PTR);
        op_write_ram   <= (op == OP_WR_RAM);
        op_read_ram_h  <= (op == OP_RD_H);
        op_read_ram_l  <= (op == OP_RD_L);
    endtask

    // hold one op until it completes and return to idle
    task automatic run_op(input int op, input word_t data);
        @(posedge CLK96);
        din <= data;
        set_ops(op);
        if (op == OP_WR_RAM || op == OP_RD_H || op == OP_RD_L) begin
            check_ack_wait(1'b0, $sformatf("op %0d", op));
            check_ack_wait(1'b1, $sformatf("op %0d", op));
        end else begin
            @(posedge CLK96);
            @(negedge CLK96);
            check_bit("ack on register op", ack, 1'b1);
        end
        @(posedge CLK96);
        set_ops(OP_IDLE);
    endtask

    task automatic set_ptr(input vram_addr_t addr);
        run_op(OP_SET_PTR, word_t'(addr));
    endtask

    task automatic write_word(input vram_addr_t addr, input word_t data);
        set_ptr(addr);
        run_op(OP_WR_RAM, data);
    endtask

    task automatic read_ram(input int op, output word_t data);
        run_op(op, '0);
        @(negedge CLK96);
        data = dout;
    endtask

    // expected register index for a select code or -1
    function automatic int reg_target(input reg_sel_t code);
        reg_sel_t sel;
        sel = code & `GCU_REG_SEL_MASK;
        if (sel[6:0] <= 7'd7) begin
            return int'(sel[2:0]);
        end
        return -1;
    endfunction

    function automatic word_t scroll_out(input int idx);
        case (idx)
            0: return bg_scroll_x;
            1: return bg_scroll_y;
            2: return fg_scroll_x;
            3: return fg_scroll_y;
            4: return txt_scroll_x;
            5: return txt_scroll_y;
            6: return spr_scroll_x;
            default: return spr_scroll_y;
        endcase
    endfunction

    function automatic word_t layer_out(input int r);
        case (r)
            0: return scr0_data;
            1: return scr1_data;
            2: return scr2_data;
            default: return spr_data;
        endcase
    endfunction

    function automatic vram_addr_t region_base(input int r);
        case (r)
            0: return `GCU_SCR0_BASE;
            1: return `GCU_SCR1_BASE;
            2: return `GCU_SCR2_BASE;
            default: return `GCU_SPR_BASE;
        endcase
    endfunction

    task automatic check_scroll_all();
        @(negedge CLK96);
        for (int i = 0; i < 8; i++) begin
            check_word($sformatf("scroll reg %0d", i), scroll_out(i), exp_scroll[i]);
        end
    endtask

    task automatic write_scroll(input reg_sel_t code, input word_t data);
        int idx;
        idx = reg_target(code);
        run_op(OP_SEL, {8'h00, code});
        run_op(OP_WR_REG, data);
        if (idx >= 0) begin
            exp_scroll[idx] = data;
        end
        check_scroll_all();
    endtask

    // all four mirror ports at one offset with data one cycle later
    task automatic read_layers(input layer_addr_t a);
        @(posedge CLK96);
        scr0_addr <= a;
        scr1_addr <= a;
        scr2_addr <= a;
        spr_addr  <= a;
        @(posedge CLK96);
        @(negedge CLK96);
    endtask

    task automatic test_reset();
        @(negedge CLK96);
        check_bit("ack after reset", ack, 1'b1);
        for (int i = 0; i < 8; i++) begin
            exp_scroll[i] = '0;
        end
        check_scroll_all();
        check_bit("vint after reset", vint, 1'b1);
        check_bit("hsync after reset", hsync, 1'b1);
        check_bit("vsync after reset", vsync, 1'b1);
        check_bit("fblank after reset", fblank, 1'b1);
    endtask

    task automatic test_scroll_regs();
        for (int i = 0; i < 8; i++) begin
            write_scroll(reg_sel_t'(i), word_t'($random(seed)));
        end
        // bit 7 set selects the same registers
        for (int i = 0; i < 8; i++) begin
            write_scroll(reg_sel_t'(8'h80 + i), word_t'($random(seed)));
        end
        write_scroll(8'h08, word_t'($random(seed)));
        write_scroll(8'h48, word_t'($random(seed)));
        write_scroll(8'h4A, word_t'($random(seed)));
        write_scroll(8'h43, word_t'($random(seed)));
    endtask

    task automatic test_ram_rw();
        word_t      wdat [8];
        word_t      got;
        vram_addr_t base;
        base = vram_addr_t'($random(seed)) & 13'h0FF8;
        set_ptr(base);
        for (int i = 0; i < 8; i++) begin
            wdat[i] = word_t'($random(seed));
            run_op(OP_WR_RAM, wdat[i]);
        end
        for (int i = 0; i < 8; i += 2) begin
            set_ptr(vram_addr_t'(base + i));
            read_ram(OP_RD_H, got);
            check_word($sformatf("read_h at +%0d", i), got, wdat[i]);
            read_ram(OP_RD_L, got);
            check_word($sformatf("read_l at +%0d", i), got, wdat[i + 1]);
            // pointer unchanged by reads
            read_ram(OP_RD_H, got);
            check_word($sformatf("repeated read_h at +%0d", i), got, wdat[i]);
        end
    endtask

    task automatic test_layer_mirrors();
        word_t       w [4];
        word_t       u [3];
        word_t       top_word;
        word_t       got;
        layer_addr_t off;
        off = layer_addr_t'($random(seed)) & 11'h3FF;
        for (int r = 0; r < 4; r++) begin
            w[r] = word_t'($random(seed));
            write_word(vram_addr_t'(region_base(r) + off), w[r]);
        end
        read_layers(off);
        for (int r = 0; r < 4; r++) begin
            check_word($sformatf("mirror %0d at %h", r, off), layer_out(r), w[r]);
        end
        // 0x1C00 is past the sprite region
        for (int r = 0; r < 3; r++) begin
            u[r] = word_t'($random(seed));
            write_word(vram_addr_t'(region_base(r) + 13'h0400), u[r]);
        end
        top_word = word_t'($random(seed));
        write_word(`GCU_SPR_END, top_word);
        read_layers(11'h400);
        for (int r = 0; r < 3; r++) begin
            check_word($sformatf("mirror %0d at 400", r), layer_out(r), u[r]);
        end
        // low 11 bits of 0x1C00 land on sprite offset 0x400
        check_word_differs("sprite mirror at 400", spr_data, top_word);
        set_ptr(`GCU_SPR_END);
        read_ram(OP_RD_H, got);
        check_word("main RAM at 1C00", got, top_word);
        read_layers(off);
        for (int r = 0; r < 4; r++) begin
            check_word($sformatf("mirror %0d reread", r), layer_out(r), w[r]);
        end
    endtask

    task automatic test_sync_blank();
        beam_t hv;
        beam_t vv;
        logic  hs_low;
        logic  vs_low;
        for (int n = 0; n < 40; n++) begin
            hv = beam_t'($random(seed) & 127);
            vv = beam_t'(80 + ($random(seed) & 63));
            hs_low = (hv > hs_start) && (hv < hs_end);
            vs_low = (vv >= vs_start) && (vv <= vs_end);
            @(posedge CLK96);
            h <= hv;
            v <= vv;
            @(posedge CLK96);
            @(negedge CLK96);
            check_bit($sformatf("hsync h=%0d", hv), hsync, !hs_low);
            check_bit($sformatf("vsync v=%0d", vv), vsync, !vs_low);
            check_bit($sformatf("fblank h=%0d v=%0d", hv, vv), fblank, !(hs_low || vs_low));
        end
    endtask

    task automatic check_vint_after(input beam_t line, input logic exp, input string what);
        @(posedge CLK96);
        v <= line;
        @(posedge CLK96);
        @(negedge CLK96);
        check_bit(what, vint, exp);
    endtask

    task automatic test_vint();
        reg_sel_t codes [4];
        codes[0] = `GCU_REG_VINT_A;
        codes[1] = `GCU_REG_VINT_B;
        codes[2] = `GCU_REG_VINT_C;
        codes[3] = 8'hCF;
        run_op(OP_SEL, 16'h0000);
        check_vint_after(`GCU_VINT_LINE, 1'b0, "vint on line 230");
        check_vint_after(9'd0, 1'b1, "vint off line 230");
        for (int i = 0; i < 4; i++) begin
            run_op(OP_SEL, {8'h00, codes[i]});
            check_vint_after(9'd0, 1'b0, $sformatf("vint held by select %h", codes[i]));
            check_vint_after(9'd10, 1'b0, $sformatf("vint still held by %h", codes[i]));
        end
        run_op(OP_SEL, 16'h0000);
        check_vint_after(9'd0, 1'b1, "vint released by select 00");
    endtask

    initial begin
        RESET96 <= 1'b1;
        din <= '0;
        set_ops(OP_IDLE);
        scr0_addr <= '0;
        scr1_addr <= '0;
        scr2_addr <= '0;
        spr_addr <= '0;
        v <= '0;
        h <= '0;
        hs_start <= 9'd20;
        hs_end <= 9'd60;
        vs_start <= 9'd100;
        vs_end <= 9'd140;
        repeat (5) @(posedge CLK96);
        RESET96 <= 1'b0;

        test_reset();
        test_scroll_regs();
        test_ram_rw();
        test_layer_mirrors();
        test_sync_blank();
        test_vint();

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
src/gcu_pkg.sv
src/gcu_dual_ram.sv
src/gcu_cmd_ctrl.sv
src/gcu_scroll_regs.sv
src/gcu_layer_rams.sv
src/gcu_video_timing.sv
src/gcu_top.sv
tests/tb_gcu.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_gcu -f filelist.f
	./obj_dir/Vtb_gcu | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
